//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data word, byte address and one strobe bit per byte lane
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;

    // memory operation as seen by the load/store unit
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8,
        MEM_LR_W = 4'd9,
        MEM_SC_W = 4'd10,
        MEM_AMO  = 4'd11
    } mem_op_e;

    // read-modify-write function, only meaningful with MEM_AMO
    typedef enum logic [3:0] {
        AMO_SWAP = 4'd0,
        AMO_ADD  = 4'd1,
        AMO_XOR  = 4'd2,
        AMO_AND  = 4'd3,
        AMO_OR   = 4'd4,
        AMO_MIN  = 4'd5,
        AMO_MAX  = 4'd6,
        AMO_MINU = 4'd7,
        AMO_MAXU = 4'd8
    } amo_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_e;

    // access sequencer
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_READ  = 3'd1,
        ST_CALC  = 3'd2,
        ST_WRITE = 3'd3,
        ST_DONE  = 3'd4
    } acc_state_e;

    // incoming request, 72 bits
    typedef struct packed {
        mem_op_e mem_op;
        amo_op_e amo_op;
        addr_t   addr;
        word_t   wdata;
    } lsu_req_t;

    // request plus decoded attributes, 85 bits
    typedef struct packed {
        lsu_req_t  req;
        acc_size_e size;
        logic      is_signed;
        logic      is_load;
        logic      is_store;
        logic      is_lr;
        logic      is_sc;
        logic      is_amo;
        // already shifted to the byte offset
        strb_t     strb;
        logic      misalign;
    } lsu_dec_t;

    // data memory port, word aligned, 69 bits
    typedef struct packed {
        addr_t addr;
        logic  we;
        strb_t strb;
        word_t wdata;
    } mem_req_t;

    // sc.w and amo report as stores
    typedef struct packed {
        logic load_misalign;
        logic store_misalign;
    } lsu_trap_t;

    typedef struct packed {
        word_t     rdata;
        lsu_trap_t trap;
    } lsu_resp_t;

endpackage

`default_nettype wire

//--- hw/lsu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_decode (
    input  lsu_pkg::lsu_req_t req_i,
    output lsu_pkg::lsu_dec_t dec_o
);
    import lsu_pkg::*;

    strb_t      base_strb;
    logic [1:0] offset;
    logic       is_atomic;
    logic       is_access;

    // byte offset inside the word
    assign offset = req_i.addr[1:0];

    always_comb begin
        dec_o      = '0;
        dec_o.req  = req_i;
        // atomics and unknown codes default to word size
        dec_o.size = SIZE_WORD;

        // classify kind, size and sign
        case (req_i.mem_op)
            MEM_LB: begin
                dec_o.size      = SIZE_BYTE;
                dec_o.is_signed = 1'b1;
                dec_o.is_load   = 1'b1;
            end
            MEM_LBU: begin
                dec_o.size    = SIZE_BYTE;
                dec_o.is_load = 1'b1;
            end
            MEM_LH: begin
                dec_o.size      = SIZE_HALF;
                dec_o.is_signed = 1'b1;
                dec_o.is_load   = 1'b1;
            end
            MEM_LHU: begin
                dec_o.size    = SIZE_HALF;
                dec_o.is_load = 1'b1;
            end
            MEM_LW:   dec_o.is_load = 1'b1;
            MEM_SB: begin
                dec_o.size     = SIZE_BYTE;
                dec_o.is_store = 1'b1;
            end
            MEM_SH: begin
                dec_o.size     = SIZE_HALF;
                dec_o.is_store = 1'b1;
            end
            MEM_SW:   dec_o.is_store = 1'b1;
            MEM_LR_W: dec_o.is_lr = 1'b1;
            MEM_SC_W: dec_o.is_sc = 1'b1;
            MEM_AMO:  dec_o.is_amo = 1'b1;
            default:  dec_o.size = SIZE_WORD;
        endcase

        // unshifted lane mask from the size
        case (dec_o.size)
            SIZE_BYTE: base_strb = 4'b0001;
            SIZE_HALF: base_strb = 4'b0011;
            default:   base_strb = 4'b1111;
        endcase
        dec_o.strb = base_strb << offset;

        is_atomic = dec_o.is_lr | dec_o.is_sc | dec_o.is_amo;
        is_access = dec_o.is_load | dec_o.is_store | is_atomic;

        // natural alignment
        // atomics decode as word size and so must sit on a word boundary
        dec_o.misalign = is_access &
                         (((dec_o.size == SIZE_HALF) & offset[0]) |
                          ((dec_o.size == SIZE_WORD) & (offset != 2'b00)));
    end

endmodule

`default_nettype wire

//--- hw/amo_alu.sv
`timescale 1ns/1ns
`default_nettype none

module amo_alu (
    input  lsu_pkg::amo_op_e amo_op_i,
    input  lsu_pkg::word_t   old_i,
    input  lsu_pkg::word_t   operand_i,
    output lsu_pkg::word_t   new_o
);
    import lsu_pkg::*;

    logic  lt_signed;
    logic  lt_unsigned;
    word_t sum;

    // two's-complement and plain magnitude compare of old against operand
    assign lt_signed   = $signed(old_i) < $signed(operand_i);
    assign lt_unsigned = old_i < operand_i;

    // add wraps modulo 2^32
    assign sum = old_i + operand_i;

    always_comb begin
        case (amo_op_i)
            AMO_SWAP: new_o = operand_i;
            AMO_ADD:  new_o = sum;
            AMO_XOR:  new_o = old_i ^ operand_i;
            AMO_AND:  new_o = old_i & operand_i;
            AMO_OR:   new_o = old_i | operand_i;
            // keep the smaller value
            AMO_MIN:  new_o = lt_signed ? old_i : operand_i;
            // keep the larger value
            AMO_MAX:  new_o = lt_signed ? operand_i : old_i;
            AMO_MINU: new_o = lt_unsigned ? old_i : operand_i;
            AMO_MAXU: new_o = lt_unsigned ? operand_i : old_i;
            // unlisted codes fall back to swap
            default:  new_o = operand_i;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/lsu_access_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_access_fsm (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  lsu_pkg::lsu_dec_t dec_i,
    output logic              mem_valid_o,
    output lsu_pkg::mem_req_t mem_req_o,
    input  logic              mem_ready_i,
    input  lsu_pkg::word_t    mem_rdata_i,
    output logic              busy_o,
    output logic              fin_o,
    output lsu_pkg::lsu_dec_t fin_dec_o,
    output lsu_pkg::word_t    raw_o,
    output logic              sc_fail_o
);
    import lsu_pkg::*;

    acc_state_e  state_q;
    acc_state_e  first_state;
    lsu_dec_t    dec_q;
    word_t       raw_q;
    word_t       lane_wdata;
    word_t       amo_new;
    logic        accept;
    logic        sc_hit;
    logic        sc_fail_q;
    logic        fin_q;
    logic        resv_valid_q;
    logic [29:0] resv_addr_q;

    assign accept = (state_q == ST_IDLE) & req_valid_i;

    // reservation is kept per word
    assign sc_hit = resv_valid_q & (resv_addr_q == dec_i.req.addr[31:2]);

    // store data moved up to its byte lanes
    assign lane_wdata = dec_i.req.wdata << {dec_i.req.addr[1:0], 3'b000};

    // first step after acceptance
    always_comb begin
        if (dec_i.misalign) begin
            first_state = ST_DONE;
        end else if (dec_i.is_load | dec_i.is_lr | dec_i.is_amo) begin
            first_state = ST_READ;
        end else if (dec_i.is_store | (dec_i.is_sc & sc_hit)) begin
            first_state = ST_WRITE;
        end else begin
            // failed sc.w and no-op skip the memory
            first_state = ST_DONE;
        end
    end

    amo_alu u_amo_alu (
        .amo_op_i  (dec_q.req.amo_op),
        .old_i     (raw_q),
        .operand_i (dec_q.req.wdata),
        .new_o     (amo_new)
    );

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            mem_valid_o  <= 1'b0;
            busy_o       <= 1'b0;
            fin_q        <= 1'b0;
            resv_valid_q <= 1'b0;
        end else begin
            // fin_q lines up with the response strobe
            fin_q <= (state_q == ST_DONE);
            if (fin_q) begin
                busy_o <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state_q     <= first_state;
                        mem_valid_o <= (first_state != ST_DONE);
                        busy_o      <= 1'b1;
                        // lr sets, any store-like access drops it
                        if (dec_i.is_lr & ~dec_i.misalign) begin
                            resv_valid_q <= 1'b1;
                        end else if (dec_i.is_sc | dec_i.is_store | dec_i.is_amo) begin
                            resv_valid_q <= 1'b0;
                        end
                    end
                end
                ST_READ: begin
                    // hold the port until the memory answers
                    if (mem_ready_i) begin
                        mem_valid_o <= 1'b0;
                        state_q     <= dec_q.is_amo ? ST_CALC : ST_DONE;
                    end
                end
                ST_CALC: begin
                    mem_valid_o <= 1'b1;
                    state_q     <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (mem_ready_i) begin
                        mem_valid_o <= 1'b0;
                        state_q     <= ST_DONE;
                    end
                end
                ST_DONE:  state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // request payload, read data and reserved word
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q           <= dec_i;
            sc_fail_q       <= dec_i.is_sc & ~sc_hit;
            mem_req_o.addr  <= {dec_i.req.addr[31:2], 2'b00};
            mem_req_o.we    <= (first_state == ST_WRITE);
            mem_req_o.strb  <= dec_i.strb;
            mem_req_o.wdata <= (first_state == ST_WRITE) ? lane_wdata : '0;
            if (dec_i.is_lr) begin
                resv_addr_q <= dec_i.req.addr[31:2];
            end
        end
        if ((state_q == ST_READ) & mem_ready_i) begin
            raw_q <= mem_rdata_i;
        end
        // amo write-back reuses the address and full strobe
        if (state_q == ST_CALC) begin
            mem_req_o.we    <= 1'b1;
            mem_req_o.wdata <= amo_new;
        end
    end

    assign fin_o     = (state_q == ST_DONE);
    assign fin_dec_o = dec_q;
    assign raw_o     = raw_q;
    assign sc_fail_o = sc_fail_q;

endmodule

`default_nettype wire

//--- hw/load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align (
    input  logic               clk,
    input  logic               rst,
    input  logic               fin_i,
    input  lsu_pkg::lsu_dec_t  dec_i,
    input  lsu_pkg::word_t     raw_i,
    input  logic               sc_fail_i,
    output logic               resp_valid_o,
    output lsu_pkg::lsu_resp_t resp_o
);
    import lsu_pkg::*;

    word_t     lane;
    word_t     rdata;
    lsu_trap_t trap;

    // addressed byte or half moved down to bit 0
    assign lane = raw_i >> {dec_i.req.addr[1:0], 3'b000};

    always_comb begin
        trap.load_misalign  = dec_i.misalign & (dec_i.is_load | dec_i.is_lr);
        trap.store_misalign = dec_i.misalign &
                              (dec_i.is_store | dec_i.is_sc | dec_i.is_amo);
        rdata = '0;
        if (dec_i.misalign) begin
            rdata = '0;
        end else if (dec_i.is_load) begin
            // sign or zero fill above the lane
            case (dec_i.size)
                SIZE_BYTE: rdata = {{24{dec_i.is_signed & lane[7]}}, lane[7:0]};
                SIZE_HALF: rdata = {{16{dec_i.is_signed & lane[15]}}, lane[15:0]};
                default:   rdata = lane;
            endcase
        end else if (dec_i.is_lr | dec_i.is_amo) begin
            // old memory value
            rdata = raw_i;
        end else if (dec_i.is_sc) begin
            // 0 on success, 1 on failure
            rdata = {31'b0, sc_fail_i};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= fin_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fin_i) begin
            resp_o.rdata <= rdata;
            resp_o.trap  <= trap;
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  logic               clk,
    input  logic               rst,
    // request side
    input  logic               req_valid_i,
    input  lsu_pkg::lsu_req_t  req_i,
    output logic               busy_o,
    // response side
    output logic               resp_valid_o,
    output lsu_pkg::lsu_resp_t resp_o,
    // data memory port
    output logic               mem_valid_o,
    output lsu_pkg::mem_req_t  mem_req_o,
    input  logic               mem_ready_i,
    input  lsu_pkg::word_t     mem_rdata_i
);
    import lsu_pkg::*;

    lsu_dec_t dec;
    lsu_dec_t fin_dec;
    word_t    raw;
    logic     fin;
    logic     sc_fail;

    // decode, combinational
    lsu_decode u_decode (
        .req_i (req_i),
        .dec_o (dec)
    );

    // execute, owns the memory port and the reservation
    lsu_access_fsm u_access_fsm (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .dec_i       (dec),
        .mem_valid_o (mem_valid_o),
        .mem_req_o   (mem_req_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i),
        .busy_o      (busy_o),
        .fin_o       (fin),
        .fin_dec_o   (fin_dec),
        .raw_o       (raw),
        .sc_fail_o   (sc_fail)
    );

    // result, one cycle after finish
    load_align u_load_align (
        .clk          (clk),
        .rst          (rst),
        .fin_i        (fin),
        .dec_i        (fin_dec),
        .raw_i        (raw),
        .sc_fail_i    (sc_fail),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    // half of the 10 ns period
    localparam int HALF_PERIOD = 5;

    initial begin
        // low first, so the first rising edge is at 5 ns
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_valid_i,
    input  lsu_pkg::mem_req_t mem_req_i,
    output logic              mem_ready_o,
    output lsu_pkg::word_t    mem_rdata_o
);
    import lsu_pkg::*;

    localparam int          DEPTH    = 64;
    localparam int          N_DELAYS = 256;
    localparam int unsigned SEED     = 32'h7a13;

    word_t      mem [DEPTH];
    int         delay_tab [N_DELAYS];
    int         delay_idx;
    int         wait_cnt;
    logic       pending;
    logic [5:0] widx;

    // every byte carries the full word index, top bits tell the lanes apart
    function automatic word_t fill_word(input int i);
        logic [5:0] a;
        a = i[5:0];
        return {2'b01, a, 2'b10, a, 2'b11, a, 2'b00, a};
    endfunction

    // word index inside the 64-word array
    assign widx = mem_req_i.addr[7:2];

    initial begin
        // one seed, all delays drawn up front in this process
        void'($urandom(SEED));
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fill_word(i);
        end
        for (int k = 0; k < N_DELAYS; k++) begin
            delay_tab[k] = $urandom_range(4, 1);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ready_o <= 1'b0;
            mem_rdata_o <= '0;
            pending     <= 1'b0;
            wait_cnt    <= 0;
            delay_idx   <= 0;
        end else begin
            // ready is a single-cycle pulse
            mem_ready_o <= 1'b0;
            if (mem_ready_o) begin
                // port drops valid on this edge, nothing to start
            end else if (mem_valid_i && !pending) begin
                pending   <= 1'b1;
                wait_cnt  <= delay_tab[delay_idx];
                delay_idx <= (delay_idx + 1) % N_DELAYS;
            end else if (pending) begin
                if (wait_cnt <= 1) begin
                    // old word goes out, then strobed bytes are merged
                    mem_rdata_o <= mem[widx];
                    if (mem_req_i.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_req_i.strb[b]) begin
                                mem[widx][8*b +: 8] = mem_req_i.wdata[8*b +: 8];
                            end
                        end
                    end
                    mem_ready_o <= 1'b1;
                    pending     <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    // one table row: request and what must come back
    typedef struct {
        string     name;
        lsu_req_t  req;
        word_t     exp_rdata;
        lsu_trap_t exp_trap;
        word_t     exp_mem;
    } vec_t;

    localparam lsu_trap_t NO_TRAP          = 2'b00;
    localparam lsu_trap_t LD_TRAP          = 2'b10;
    localparam lsu_trap_t ST_TRAP          = 2'b01;
    localparam int        CYCLES_PER_ENTRY = 20;

    logic      clk;
    logic      rst;
    logic      req_valid;
    lsu_req_t  req;
    logic      busy;
    logic      resp_valid;
    lsu_resp_t resp;
    logic      mem_valid;
    mem_req_t  mem_req;
    logic      mem_ready;
    word_t     mem_rdata;

    vec_t vecs [$];
    int   cycle_cnt        = 0;
    int   cycle_limit      = 0;
    int   mem_valid_cycles = 0;

    tb_clk_gen u_clk (
        .clk_o (clk)
    );

    lsu_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .busy_o       (busy),
        .resp_valid_o (resp_valid),
        .resp_o       (resp),
        .mem_valid_o  (mem_valid),
        .mem_req_o    (mem_req),
        .mem_ready_i  (mem_ready),
        .mem_rdata_i  (mem_rdata)
    );

    tb_mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_valid_i (mem_valid),
        .mem_req_i   (mem_req),
        .mem_ready_o (mem_ready),
        .mem_rdata_o (mem_rdata)
    );

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input string what,
                              input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %08h actual %08h", name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_trap(input string name, input lsu_trap_t exp, input lsu_trap_t act);
        if (act !== exp) begin
            $display("Error: %s trap expected %02b actual %02b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic add_entry(input string name, input mem_op_e op, input amo_op_e fn,
                             input addr_t addr, input word_t wdata, input word_t rdata,
                             input lsu_trap_t trap, input word_t mem_after);
        vec_t v;
        v.name       = name;
        v.req.mem_op = op;
        v.req.amo_op = fn;
        v.req.addr   = addr;
        v.req.wdata  = wdata;
        v.exp_rdata  = rdata;
        v.exp_trap   = trap;
        v.exp_mem    = mem_after;
        vecs.push_back(v);
    endtask

    task automatic build_table();
        // word 1 holds 4181c101, loads at every legal offset
        add_entry("lb 0", MEM_LB, AMO_SWAP, 'h04, 'h0, 'h00000001, NO_TRAP, 'h4181c101);
        add_entry("lb 1", MEM_LB, AMO_SWAP, 'h05, 'h0, 'hffffffc1, NO_TRAP, 'h4181c101);
        add_entry("lb 2", MEM_LB, AMO_SWAP, 'h06, 'h0, 'hffffff81, NO_TRAP, 'h4181c101);
        add_entry("lb 3", MEM_LB, AMO_SWAP, 'h07, 'h0, 'h00000041, NO_TRAP, 'h4181c101);
        add_entry("lbu 0", MEM_LBU, AMO_SWAP, 'h04, 'h0, 'h00000001, NO_TRAP, 'h4181c101);
        add_entry("lbu 1", MEM_LBU, AMO_SWAP, 'h05, 'h0, 'h000000c1, NO_TRAP, 'h4181c101);
        add_entry("lbu 2", MEM_LBU, AMO_SWAP, 'h06, 'h0, 'h00000081, NO_TRAP, 'h4181c101);
        add_entry("lbu 3", MEM_LBU, AMO_SWAP, 'h07, 'h0, 'h00000041, NO_TRAP, 'h4181c101);
        add_entry("lh 0", MEM_LH, AMO_SWAP, 'h04, 'h0, 'hffffc101, NO_TRAP, 'h4181c101);
        add_entry("lh 2", MEM_LH, AMO_SWAP, 'h06, 'h0, 'h00004181, NO_TRAP, 'h4181c101);
        add_entry("lhu 0", MEM_LHU, AMO_SWAP, 'h04, 'h0, 'h0000c101, NO_TRAP, 'h4181c101);
        add_entry("lhu 2", MEM_LHU, AMO_SWAP, 'h06, 'h0, 'h00004181, NO_TRAP, 'h4181c101);
        add_entry("lw", MEM_LW, AMO_SWAP, 'h04, 'h0, 'h4181c101, NO_TRAP, 'h4181c101);
        // narrow stores, upper wdata bits must not leak into memory
        add_entry("sb 0", MEM_SB, AMO_SWAP, 'h08, 'h123456a5, 'h0, NO_TRAP, 'h4282c2a5);
        add_entry("sb 1", MEM_SB, AMO_SWAP, 'h09, 'hdeadbe5a, 'h0, NO_TRAP, 'h42825aa5);
        add_entry("sb 2", MEM_SB, AMO_SWAP, 'h0a, 'h0000003c, 'h0, NO_TRAP, 'h423c5aa5);
        add_entry("sb 3", MEM_SB, AMO_SWAP, 'h0b, 'hff0000e7, 'h0, NO_TRAP, 'he73c5aa5);
        add_entry("sh 0", MEM_SH, AMO_SWAP, 'h0c, 'haaaa1234, 'h0, NO_TRAP, 'h43831234);
        add_entry("sh 2", MEM_SH, AMO_SWAP, 'h0e, 'h5555beef, 'h0, NO_TRAP, 'hbeef1234);
        add_entry("sw", MEM_SW, AMO_SWAP, 'h10, 'hcafef00d, 'h0, NO_TRAP, 'hcafef00d);
        // one word per amo function, old word comes back
        add_entry("swap", MEM_AMO, AMO_SWAP, 'h14, 'h11223344, 'h4585c505, NO_TRAP, 'h11223344);
        add_entry("add", MEM_AMO, AMO_ADD, 'h18, 'hc0000000, 'h4686c606, NO_TRAP, 'h0686c606);
        add_entry("xor", MEM_AMO, AMO_XOR, 'h1c, 'hffff0000, 'h4787c707, NO_TRAP, 'hb878c707);
        add_entry("and", MEM_AMO, AMO_AND, 'h20, 'h0ff00ff0, 'h4888c808, NO_TRAP, 'h08800800);
        add_entry("or", MEM_AMO, AMO_OR, 'h24, 'h00f000f0, 'h4989c909, NO_TRAP, 'h49f9c9f9);
        // negative operand against a positive old word
        add_entry("min", MEM_AMO, AMO_MIN, 'h28, 'h80000001, 'h4a8aca0a, NO_TRAP, 'h80000001);
        add_entry("max", MEM_AMO, AMO_MAX, 'h2c, 'h80000001, 'h4b8bcb0b, NO_TRAP, 'h4b8bcb0b);
        add_entry("minu", MEM_AMO, AMO_MINU, 'h30, 'h80000001, 'h4c8ccc0c, NO_TRAP, 'h4c8ccc0c);
        add_entry("maxu", MEM_AMO, AMO_MAXU, 'h34, 'h80000001, 'h4d8dcd0d, NO_TRAP, 'h80000001);
        // lr then two sc, second one has lost the reservation
        add_entry("lr a", MEM_LR_W, AMO_SWAP, 'h38, 'h0, 'h4e8ece0e, NO_TRAP, 'h4e8ece0e);
        add_entry("sc a1", MEM_SC_W, AMO_SWAP, 'h38, 'h600dcafe, 'h0, NO_TRAP, 'h600dcafe);
        add_entry("sc a2", MEM_SC_W, AMO_SWAP, 'h38, 'hbadbad00, 'h1, NO_TRAP, 'h600dcafe);
        // plain store between lr and sc kills the reservation
        add_entry("lr b", MEM_LR_W, AMO_SWAP, 'h3c, 'h0, 'h4f8fcf0f, NO_TRAP, 'h4f8fcf0f);
        add_entry("sw b", MEM_SW, AMO_SWAP, 'h3c, 'h13572468, 'h0, NO_TRAP, 'h13572468);
        add_entry("sc b", MEM_SC_W, AMO_SWAP, 'h3c, 'h99999999, 'h1, NO_TRAP, 'h13572468);
        // misaligned, word 16 must stay 5090d010
        add_entry("lh odd", MEM_LH, AMO_SWAP, 'h41, 'h0, 'h0, LD_TRAP, 'h5090d010);
        add_entry("sw off2", MEM_SW, AMO_SWAP, 'h42, 'hffffffff, 'h0, ST_TRAP, 'h5090d010);
        add_entry("amo off2", MEM_AMO, AMO_ADD, 'h42, 'h00000001, 'h0, ST_TRAP, 'h5090d010);
    endtask

    // run-length guard and memory port activity counter
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (mem_valid) begin
            mem_valid_cycles <= mem_valid_cycles + 1;
        end
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            fail_run();
        end
    end

    initial begin
        int lat;
        int valid_before;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        cycle_limit = vecs.size() * CYCLES_PER_ENTRY;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < vecs.size(); k++) begin
            valid_before = mem_valid_cycles;
            req          = vecs[k].req;
            req_valid    = 1'b1;
            @(negedge clk);
            req_valid = 1'b0;
            // busy from the cycle after acceptance
            check_flag(vecs[k].name, "busy after accept", 1'b1, busy);
            // latency counted in falling edges after the strobe
            lat = 1;
            while (!resp_valid) begin
                @(negedge clk);
                lat++;
            end
            check_flag(vecs[k].name, "busy with response", 1'b1, busy);
            check_word(vecs[k].name, "rdata", vecs[k].exp_rdata, resp.rdata);
            check_trap(vecs[k].name, vecs[k].exp_trap, resp.trap);
            check_word(vecs[k].name, "memory", vecs[k].exp_mem,
                       u_mem.mem[vecs[k].req.addr[7:2]]);
            if (vecs[k].exp_trap != NO_TRAP) begin
                if (lat != 2) begin
                    $display("Error: %s latency expected 2 actual %0d",
                             vecs[k].name, lat);
                    fail_run();
                end
                check_flag(vecs[k].name, "memory port used", 1'b0,
                           mem_valid_cycles != valid_before);
            end
            // response is a one-cycle strobe
            @(negedge clk);
            check_flag(vecs[k].name, "response valid held", 1'b0, resp_valid);
            // unit is free again one cycle after the response
            check_flag(vecs[k].name, "busy after response", 1'b0, busy);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/amo_alu.sv
hw/lsu_access_fsm.sv
hw/load_align.sv
hw/lsu_top.sv
sim/tb_clk_gen.sv
sim/tb_mem_model.sv
sim/tb_lsu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_lsu
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

# build and run; the exit status of the simulation is the result
all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
